/* core_pkg.sv */
/*
 * core package
 * widths, opcodes, the ALU operation set, the instruction union and the
 * pipeline register structs shared by the five-stage core
 */
package core_pkg;

  localparam int data_width = 32;
  localparam int reg_addr_width = 5;
  localparam int mask_width = 4;

  // opcodes of the supported subset
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal = 7'b1101111;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [6:0] f7_sub = 7'b0100000;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_imm
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0] funct3;
    logic [reg_addr_width-1:0] rd;
    logic [6:0] opcode;
  } r_type_s;

  typedef struct packed {
    logic [11:0] imm;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0] funct3;
    logic [reg_addr_width-1:0] rd;
    logic [6:0] opcode;
  } i_type_s;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_s;

  typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    logic [reg_addr_width-1:0] rs2;
    logic [reg_addr_width-1:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic imm_11;
    logic [6:0] opcode;
  } b_type_s;

  typedef struct packed {
    logic [19:0] imm;
    logic [reg_addr_width-1:0] rd;
    logic [6:0] opcode;
  } u_type_s;

  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    logic [reg_addr_width-1:0] rd;
    logic [6:0] opcode;
  } j_type_s;

  typedef union packed {
    r_type_s r;
    i_type_s i;
    s_type_s s;
    b_type_s b;
    u_type_s u;
    j_type_s j;
  } instr_u;

  typedef struct packed {
    logic reads_rs1;
    logic reads_rs2;
    logic writes_rd;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic branch_on_equal;
    logic is_jal;
    logic uses_imm;
    alu_op_e alu_op;
  } decode_s;

  // addr is a byte address, data memory uses the word part
  typedef struct packed {
    logic w;
    logic [data_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [mask_width-1:0] mask;
  } dmem_req_s;

  typedef struct packed {
    logic valid;
    logic [data_width-1:0] pc;
    instr_u instr;
  } id_reg_s;

  typedef struct packed {
    logic valid;
    logic [data_width-1:0] pc;
    decode_s decode;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [data_width-1:0] rs1_val;
    logic [data_width-1:0] rs2_val;
    logic [data_width-1:0] imm;
  } exe_reg_s;

  typedef struct packed {
    logic valid;
    logic writes_rd;
    logic is_load;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0] result;
  } mem_reg_s;

  typedef struct packed {
    logic writes_rd;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0] data;
  } wb_reg_s;

endpackage

/* fetch_stage.sv */
/*
 * fetch stage
 * program counter, next-pc selection and the writable instruction store
 */
module fetch_stage #(
  parameter int imem_els_p = 64
) (
  input clk_i,
  input reset_i,
  input [core_pkg::data_width-1:0] pc_init_val_i,
  input imem_v_i,
  input [core_pkg::data_width-1:0] imem_addr_i,
  input [core_pkg::data_width-1:0] imem_instr_i,
  input hold_i,
  input redirect_i,
  input [core_pkg::data_width-1:0] redirect_pc_i,
  output logic imem_yumi_o,
  output core_pkg::id_reg_s id_n_o
);
  import core_pkg::*;

  localparam int addr_width_lp = $clog2(imem_els_p);

  logic [data_width-1:0] imem_r [imem_els_p];
  logic [data_width-1:0] pc_r;
  logic [data_width-1:0] pc_n;
  logic reset_r;

  // store writes always win, fetch just waits a cycle
  assign imem_yumi_o = imem_v_i;

  always_comb begin
    if (reset_r) begin
      pc_n = pc_init_val_i;
    end else if (redirect_i) begin
      pc_n = redirect_pc_i;
    end else if (hold_i | imem_v_i) begin
      pc_n = pc_r;
    end else begin
      pc_n = pc_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
    if (reset_i) begin
      pc_r <= '0;
    end else begin
      pc_r <= pc_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (imem_v_i) begin
      imem_r[imem_addr_i[addr_width_lp-1:0]] <= imem_instr_i;
    end
  end

  // redirect turns the word behind the branch into a bubble
  assign id_n_o.valid = ~reset_i & ~reset_r & ~redirect_i & ~imem_v_i;
  assign id_n_o.pc = pc_r;
  assign id_n_o.instr = imem_r[pc_r[addr_width_lp-1:0]];

  imem_addr_range: assert property (@(posedge clk_i) imem_v_i |-> imem_addr_i < imem_els_p);

endmodule

/* decode_unit.sv */
/*
 * instruction decoder
 * control struct and sign-extended immediate, unknown encodings give a no-op
 */
module decode_unit (
  input core_pkg::instr_u instr_i,
  output core_pkg::decode_s decode_o,
  output logic [core_pkg::data_width-1:0] imm_o
);
  import core_pkg::*;

  logic known;

  always_comb begin
    decode_o = '0;
    imm_o = '0;
    known = 1'b1;
    case (instr_i.r.opcode)
      op_lui: begin
        decode_o.writes_rd = 1'b1;
        decode_o.uses_imm = 1'b1;
        decode_o.alu_op = alu_pass_imm;
        imm_o = {instr_i.u.imm, 12'b0};
      end
      op_imm, op_reg: begin
        decode_o.reads_rs1 = 1'b1;
        decode_o.reads_rs2 = (instr_i.r.opcode == op_reg);
        decode_o.writes_rd = 1'b1;
        decode_o.uses_imm = (instr_i.r.opcode == op_imm);
        imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        case (instr_i.r.funct3)
          f3_add: begin
            // funct7 only means sub for register ops
            if (instr_i.r.opcode == op_reg && instr_i.r.funct7 == f7_sub) begin
              decode_o.alu_op = alu_sub;
            end else begin
              decode_o.alu_op = alu_add;
            end
          end
          f3_slt: decode_o.alu_op = alu_slt;
          f3_xor: decode_o.alu_op = alu_xor;
          f3_or: decode_o.alu_op = alu_or;
          f3_and: decode_o.alu_op = alu_and;
          default: known = 1'b0;
        endcase
      end
      op_load: begin
        decode_o.reads_rs1 = 1'b1;
        decode_o.writes_rd = 1'b1;
        decode_o.is_load = 1'b1;
        decode_o.uses_imm = 1'b1;
        imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        known = (instr_i.i.funct3 == f3_word);
      end
      op_store: begin
        decode_o.reads_rs1 = 1'b1;
        decode_o.reads_rs2 = 1'b1;
        decode_o.is_store = 1'b1;
        decode_o.uses_imm = 1'b1;
        imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        known = (instr_i.s.funct3 == f3_word);
      end
      op_branch: begin
        decode_o.reads_rs1 = 1'b1;
        decode_o.reads_rs2 = 1'b1;
        decode_o.is_branch = 1'b1;
        decode_o.branch_on_equal = (instr_i.b.funct3 == f3_beq);
        imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                 instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
        known = (instr_i.b.funct3 == f3_beq) || (instr_i.b.funct3 == f3_bne);
      end
      op_jal: begin
        decode_o.writes_rd = 1'b1;
        decode_o.is_jal = 1'b1;
        imm_o = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                 instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
      end
      default: known = 1'b0;
    endcase
    if (!known) begin
      decode_o = '0;
      imm_o = '0;
    end
  end

endmodule

/* regfile.sv */
/*
 * integer register file
 * two asynchronous reads with write-through, one write, x0 fixed at zero
 */
module regfile (
  input clk_i,
  input [core_pkg::reg_addr_width-1:0] rs1_i,
  input [core_pkg::reg_addr_width-1:0] rs2_i,
  input w_v_i,
  input [core_pkg::reg_addr_width-1:0] w_addr_i,
  input [core_pkg::data_width-1:0] w_data_i,
  output logic [core_pkg::data_width-1:0] rs1_data_o,
  output logic [core_pkg::data_width-1:0] rs2_data_o
);
  import core_pkg::*;

  logic [data_width-1:0] regs_r [2**reg_addr_width];
  logic w_en;

  assign w_en = w_v_i & (w_addr_i != '0);

  always_ff @(posedge clk_i) begin
    if (w_en) begin
      regs_r[w_addr_i] <= w_data_i;
    end
  end

  // same-cycle writeback reaches decode directly
  assign rs1_data_o = (rs1_i == '0) ? '0 : (w_en && w_addr_i == rs1_i) ? w_data_i : regs_r[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : (w_en && w_addr_i == rs2_i) ? w_data_i : regs_r[rs2_i];

endmodule

/* alu.sv */
/*
 * execute ALU
 * arithmetic, logic, signed compare and the branch decision with its target
 */
module alu (
  input core_pkg::alu_op_e op_i,
  input [core_pkg::data_width-1:0] a_i,
  input [core_pkg::data_width-1:0] b_i,
  input [core_pkg::data_width-1:0] pc_i,
  input [core_pkg::data_width-1:0] imm_i,
  input core_pkg::decode_s decode_i,
  output logic [core_pkg::data_width-1:0] result_o,
  output logic branch_taken_o,
  output logic [core_pkg::data_width-1:0] target_o
);
  import core_pkg::*;

  logic equal;
  logic less;

  assign equal = (a_i == b_i);
  assign less = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      alu_sub: result_o = a_i - b_i;
      alu_and: result_o = a_i & b_i;
      alu_or: result_o = a_i | b_i;
      alu_xor: result_o = a_i ^ b_i;
      alu_slt: result_o = {{(data_width-1){1'b0}}, less};
      alu_pass_imm: result_o = imm_i;
      default: result_o = a_i + b_i;
    endcase
    // link value is the byte address of the next word
    if (decode_i.is_jal) begin
      result_o = (pc_i + 1'b1) << 2;
    end
  end

  assign branch_taken_o = decode_i.is_jal
                        | (decode_i.is_branch & (equal == decode_i.branch_on_equal));

  // pc counts words, the immediate counts bytes
  assign target_o = pc_i + {{2{imm_i[data_width-1]}}, imm_i[data_width-1:2]};

endmodule

/* hazard_unit.sv */
/*
 * hazard unit
 * forwarding selects for execute, the load-use stall and the branch flush
 */
module hazard_unit (
  input clk_i,
  input reset_i,
  input [core_pkg::reg_addr_width-1:0] id_rs1_i,
  input [core_pkg::reg_addr_width-1:0] id_rs2_i,
  input [1:0] id_reads_i,
  input core_pkg::exe_reg_s exe_i,
  input core_pkg::mem_reg_s mem_i,
  input core_pkg::wb_reg_s wb_i,
  input branch_taken_i,
  output core_pkg::fwd_sel_e rs1_fwd_o,
  output core_pkg::fwd_sel_e rs2_fwd_o,
  output logic load_use_stall_o,
  output logic flush_o
);
  import core_pkg::*;

  logic mem_writes;
  logic exe_load;

  function automatic logic hit(input logic [reg_addr_width-1:0] rs,
                               input logic reads,
                               input logic writes,
                               input logic [reg_addr_width-1:0] rd);
    return reads && writes && (rs != '0) && (rs == rd);
  endfunction

  assign mem_writes = mem_i.valid & mem_i.writes_rd;
  assign exe_load = exe_i.valid & exe_i.decode.is_load;

  // nearest producer wins
  assign rs1_fwd_o = hit(exe_i.rs1, exe_i.decode.reads_rs1, mem_writes, mem_i.rd) ? fwd_mem :
                     hit(exe_i.rs1, exe_i.decode.reads_rs1, wb_i.writes_rd, wb_i.rd) ? fwd_wb :
                     fwd_none;
  assign rs2_fwd_o = hit(exe_i.rs2, exe_i.decode.reads_rs2, mem_writes, mem_i.rd) ? fwd_mem :
                     hit(exe_i.rs2, exe_i.decode.reads_rs2, wb_i.writes_rd, wb_i.rd) ? fwd_wb :
                     fwd_none;

  assign load_use_stall_o = hit(id_rs1_i, id_reads_i[0], exe_load, exe_i.rd)
                          | hit(id_rs2_i, id_reads_i[1], exe_load, exe_i.rd);

  assign flush_o = exe_i.valid & branch_taken_i;

  stall_flush_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(load_use_stall_o && flush_o));

endmodule

/* data_mem.sv */
/*
 * local data memory
 * byte-masked word array shared by the core and the remote port,
 * core first, last read word held on the outputs
 */
module data_mem #(
  parameter int dmem_els_p = 64
) (
  input clk_i,
  input core_v_i,
  input core_pkg::dmem_req_s core_req_i,
  input remote_v_i,
  input core_pkg::dmem_req_s remote_req_i,
  output logic remote_yumi_o,
  output logic [core_pkg::data_width-1:0] load_data_o,
  output logic [core_pkg::data_width-1:0] remote_data_o
);
  import core_pkg::*;

  localparam int addr_width_lp = $clog2(dmem_els_p);

  logic [data_width-1:0] mem_r [dmem_els_p];
  logic [data_width-1:0] read_data_r;
  dmem_req_s req;
  logic v;
  logic [addr_width_lp-1:0] idx;

  // remote waits whenever execute has a memory op
  assign remote_yumi_o = remote_v_i & ~core_v_i;
  assign v = core_v_i | remote_v_i;
  assign req = core_v_i ? core_req_i : remote_req_i;
  assign idx = req.addr[2 +: addr_width_lp];

  always_ff @(posedge clk_i) begin
    if (v & req.w) begin
      for (int b = 0; b < mask_width; b++) begin
        if (req.mask[b]) begin
          mem_r[idx][8*b +: 8] <= req.data[8*b +: 8];
        end
      end
    end
  end

  // one read register, the word stays until the next read by either side
  always_ff @(posedge clk_i) begin
    if (v & ~req.w) begin
      read_data_r <= mem_r[idx];
    end
  end

  assign load_data_o = read_data_r;
  assign remote_data_o = read_data_r;

  dmem_addr_range: assert property (@(posedge clk_i)
    v |-> req.addr[data_width-1:2] < dmem_els_p);

endmodule

/* vanilla_core.sv */
/*
 * five-stage integer core
 * fetch, decode, execute, memory and writeback with forwarding,
 * a load-use stall and branch flush in execute
 */
module vanilla_core #(
  parameter int imem_els_p = 64,
  parameter int dmem_els_p = 64
) (
  input clk_i,
  input reset_i,
  input [core_pkg::data_width-1:0] pc_init_val_i,
  input imem_v_i,
  input [core_pkg::data_width-1:0] imem_addr_i,
  input [core_pkg::data_width-1:0] imem_instr_i,
  output logic imem_yumi_o,
  input remote_dmem_v_i,
  input core_pkg::dmem_req_s remote_dmem_req_i,
  output logic remote_dmem_yumi_o,
  output logic [core_pkg::data_width-1:0] remote_dmem_data_o
);
  import core_pkg::*;

  id_reg_s id_r, id_n;
  exe_reg_s exe_r, exe_n;
  mem_reg_s mem_r, mem_n;
  wb_reg_s wb_r, wb_n;

  logic stall;
  logic flush;
  logic branch_taken;
  logic [data_width-1:0] branch_target;
  decode_s id_decode;
  logic [data_width-1:0] id_imm;
  logic [data_width-1:0] rs1_val, rs2_val;
  fwd_sel_e rs1_sel, rs2_sel;
  logic [data_width-1:0] rs1_fwd, rs2_fwd;
  logic [data_width-1:0] alu_b;
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] load_data;
  logic [data_width-1:0] mem_val;
  logic core_v;
  dmem_req_s core_req;

  function automatic logic [data_width-1:0] fwd_pick(input fwd_sel_e sel,
                                                     input logic [data_width-1:0] reg_val,
                                                     input logic [data_width-1:0] mem_v,
                                                     input logic [data_width-1:0] wb_v);
    case (sel)
      fwd_mem: return mem_v;
      fwd_wb: return wb_v;
      default: return reg_val;
    endcase
  endfunction

  fetch_stage #(.imem_els_p(imem_els_p)) fetch (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pc_init_val_i(pc_init_val_i),
    .imem_v_i(imem_v_i),
    .imem_addr_i(imem_addr_i),
    .imem_instr_i(imem_instr_i),
    .hold_i(stall),
    .redirect_i(flush),
    .redirect_pc_i(branch_target),
    .imem_yumi_o(imem_yumi_o),
    .id_n_o(id_n)
  );

  decode_unit dec (.instr_i(id_r.instr), .decode_o(id_decode), .imm_o(id_imm));

  regfile rf (
    .clk_i(clk_i),
    .rs1_i(id_r.instr.r.rs1),
    .rs2_i(id_r.instr.r.rs2),
    .w_v_i(wb_r.writes_rd),
    .w_addr_i(wb_r.rd),
    .w_data_i(wb_r.data),
    .rs1_data_o(rs1_val),
    .rs2_data_o(rs2_val)
  );

  hazard_unit haz (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .id_rs1_i(id_r.instr.r.rs1),
    .id_rs2_i(id_r.instr.r.rs2),
    .id_reads_i({id_r.valid & id_decode.reads_rs2, id_r.valid & id_decode.reads_rs1}),
    .exe_i(exe_r),
    .mem_i(mem_r),
    .wb_i(wb_r),
    .branch_taken_i(branch_taken),
    .rs1_fwd_o(rs1_sel),
    .rs2_fwd_o(rs2_sel),
    .load_use_stall_o(stall),
    .flush_o(flush)
  );

  // a stall or flush sends a bubble into execute
  always_comb begin
    exe_n = '{valid: id_r.valid & ~stall & ~flush, pc: id_r.pc, decode: id_decode,
              rd: id_r.instr.r.rd, rs1: id_r.instr.r.rs1, rs2: id_r.instr.r.rs2,
              rs1_val: rs1_val, rs2_val: rs2_val, imm: id_imm};
  end

  // loads hand back memory data once they leave execute
  assign mem_val = mem_r.is_load ? load_data : mem_r.result;
  assign rs1_fwd = fwd_pick(rs1_sel, exe_r.rs1_val, mem_val, wb_r.data);
  assign rs2_fwd = fwd_pick(rs2_sel, exe_r.rs2_val, mem_val, wb_r.data);
  assign alu_b = exe_r.decode.uses_imm ? exe_r.imm : rs2_fwd;

  alu ex_alu (
    .op_i(exe_r.decode.alu_op),
    .a_i(rs1_fwd),
    .b_i(alu_b),
    .pc_i(exe_r.pc),
    .imm_i(exe_r.imm),
    .decode_i(exe_r.decode),
    .result_o(alu_result),
    .branch_taken_o(branch_taken),
    .target_o(branch_target)
  );

  assign core_v = exe_r.valid & (exe_r.decode.is_load | exe_r.decode.is_store);
  assign core_req = '{w: exe_r.decode.is_store, addr: alu_result, data: rs2_fwd, mask: '1};

  data_mem #(.dmem_els_p(dmem_els_p)) dmem (
    .clk_i(clk_i),
    .core_v_i(core_v),
    .core_req_i(core_req),
    .remote_v_i(remote_dmem_v_i),
    .remote_req_i(remote_dmem_req_i),
    .remote_yumi_o(remote_dmem_yumi_o),
    .load_data_o(load_data),
    .remote_data_o(remote_dmem_data_o)
  );

  assign mem_n = '{valid: exe_r.valid, writes_rd: exe_r.valid & exe_r.decode.writes_rd,
                   is_load: exe_r.decode.is_load, rd: exe_r.rd, result: alu_result};
  assign wb_n = '{writes_rd: mem_r.valid & mem_r.writes_rd, rd: mem_r.rd, data: mem_val};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_r <= '0;
      exe_r <= '0;
      mem_r <= '0;
      wb_r <= '0;
    end else begin
      if (!stall) begin
        id_r <= id_n;
      end
      exe_r <= exe_n;
      mem_r <= mem_n;
      wb_r <= wb_n;
    end
  end

  // fetch drops the word it was reading when a branch is taken
  flush_bubble: assert property (@(posedge clk_i) disable iff (reset_i)
    flush |=> !id_r.valid);

endmodule

/* tb_programs.svh */
/*
 * program helpers for the core testbench
 * instruction encoders, the random program builder and a reference
 * interpreter that predicts the data memory contents
 */

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                      input int rd, input int rs1, input int rs2);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
endfunction

function automatic logic [31:0] enc_lui(input int rd, input int imm20);
  return {imm20[19:0], rd[4:0], op_lui};
endfunction

function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int off);
  return {off[11:5], rs2[4:0], rs1[4:0], f3_word, off[4:0], op_store};
endfunction

// offsets are in bytes
function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] enc_jal(input int rd, input int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
endfunction

function automatic void emit(input logic [31:0] instr);
  if (prog_len < imem_words) begin
    prog[prog_len] = instr;
    prog_len++;
  end
endfunction

// every program ends spinning on itself
function automatic void emit_halt();
  emit(enc_b(f3_beq, 0, 0, 0));
endfunction

function automatic logic [2:0] pick_f3(input int k);
  case (k)
    0: return f3_add;
    1: return f3_slt;
    2: return f3_xor;
    3: return f3_or;
    default: return f3_and;
  endcase
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b010: return {31'b0, $signed(a) < $signed(b)};
    3'b100: return a ^ b;
    3'b110: return a | b;
    3'b111: return a & b;
    default: return '0;
  endcase
endfunction

// runs prog from word 0 on top of the current exp_mem
function automatic void ref_run();
  logic [31:0] x [32];
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] addr;
  logic [31:0] off;
  int pc;
  int next_pc;
  int widx;
  bit wr;
  for (int r = 0; r < 32; r++) begin
    x[r] = '0;
  end
  pc = 0;
  for (int step = 0; step < 4 * prog_len; step++) begin
    if (pc < 0 || pc >= prog_len) begin
      break;
    end
    w = prog[pc];
    a = x[w[19:15]];
    b = x[w[24:20]];
    res = '0;
    wr = 1'b0;
    next_pc = pc + 1;
    case (w[6:0])
      op_lui: begin
        res = {w[31:12], 12'b0};
        wr = 1'b1;
      end
      op_imm: begin
        res = alu_model(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        wr = 1'b1;
      end
      op_reg: begin
        res = alu_model(w[14:12], w[30], a, b);
        wr = 1'b1;
      end
      op_load: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        widx = int'(addr >> 2);
        res = exp_mem[widx];
        wr = 1'b1;
      end
      op_store: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        widx = int'(addr >> 2);
        exp_mem[widx] = b;
        exp_known[widx] = 1'b1;
      end
      op_branch: begin
        off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        if ((a == b) == (w[14:12] == f3_beq)) begin
          next_pc = pc + int'($signed(off) >>> 2);
        end
      end
      op_jal: begin
        off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res = (pc + 1) * 4;
        wr = 1'b1;
        next_pc = pc + int'($signed(off) >>> 2);
      end
      default: begin
      end
    endcase
    if (wr && w[11:7] != 5'd0) begin
      x[w[11:7]] = res;
    end
    if (next_pc == pc) begin
      break;
    end
    pc = next_pc;
  end
endfunction

// straight-line program over x1..x7, results stored to words 16..22
function automatic void build_random(input int body_len);
  bit stored [16];
  int kind;
  int rd;
  int rs1;
  int rs2;
  int word;
  logic [2:0] f3;
  for (int k = 0; k < 16; k++) begin
    stored[k] = 1'b0;
  end
  for (int r = 1; r < 8; r++) begin
    emit(enc_i(op_imm, f3_add, r, 0, int'($urandom)));
  end
  for (int n = 0; n < body_len; n++) begin
    kind = $urandom_range(4, 0);
    rd = $urandom_range(7, 1);
    rs1 = $urandom_range(7, 0);
    rs2 = $urandom_range(7, 0);
    word = $urandom_range(15, 0);
    f3 = pick_f3($urandom_range(4, 0));
    case (kind)
      0: emit(enc_i(op_imm, f3, rd, rs1, int'($urandom)));
      1: emit(enc_r(f3, (f3 == f3_add && $urandom_range(1, 0) == 1) ? f7_sub : 7'b0,
                    rd, rs1, rs2));
      2: emit(enc_lui(rd, int'($urandom)));
      3: begin
        emit(enc_s(rs2, 0, word * 4));
        stored[word] = 1'b1;
      end
      default: begin
        // only load words this program already wrote
        if (stored[word]) begin
          emit(enc_i(op_load, f3_word, rd, 0, word * 4));
        end else begin
          emit(enc_r(f3_add, 7'b0, rd, rs1, rs2));
        end
      end
    endcase
  end
  for (int r = 1; r < 8; r++) begin
    emit(enc_s(r, 0, (15 + r) * 4));
  end
  emit_halt();
endfunction

/* tb_vanilla_core.sv */
/*
 * testbench for the five-stage core
 * loads programs, runs them against the reference interpreter and
 * reads the data memory back through the remote port
 */
module tb_vanilla_core;
  import core_pkg::*;

  localparam int imem_words = 64;
  localparam int dmem_words = 64;
  localparam int reset_cycles = 10;
  localparam int drive_delay = 10;
  localparam int handshake_limit = 20;

  logic clk_i;
  logic reset_i;
  logic [data_width-1:0] pc_init_val_i;
  logic imem_v_i;
  logic [data_width-1:0] imem_addr_i;
  logic [data_width-1:0] imem_instr_i;
  logic imem_yumi_o;
  logic remote_dmem_v_i;
  dmem_req_s remote_dmem_req_i;
  logic remote_dmem_yumi_o;
  logic [data_width-1:0] remote_dmem_data_o;

  logic [31:0] prog [imem_words];
  int prog_len;
  logic [31:0] exp_mem [dmem_words];
  bit exp_known [dmem_words];
  int cycle_count;
  int reset_start;
  bit hung;
  int tests_run;
  int tests_failed;
  int total_mismatches;

  `include "tb_programs.svh"

  vanilla_core #(.imem_els_p(imem_words), .dmem_els_p(dmem_words)) dut (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pc_init_val_i(pc_init_val_i),
    .imem_v_i(imem_v_i),
    .imem_addr_i(imem_addr_i),
    .imem_instr_i(imem_instr_i),
    .imem_yumi_o(imem_yumi_o),
    .remote_dmem_v_i(remote_dmem_v_i),
    .remote_dmem_req_i(remote_dmem_req_i),
    .remote_dmem_yumi_o(remote_dmem_yumi_o),
    .remote_dmem_data_o(remote_dmem_data_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic drive_edge();
    @(posedge clk_i);
    #drive_delay;
    cycle_count++;
  endtask

  // leaves the request up, the next call or launch takes it down
  task automatic write_instr(input int addr, input logic [31:0] instr);
    int waited;
    drive_edge();
    imem_v_i = 1'b1;
    imem_addr_i = addr;
    imem_instr_i = instr;
    waited = 0;
    @(negedge clk_i);
    while (!imem_yumi_o && waited < handshake_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!imem_yumi_o) begin
      hung = 1'b1;
      $display("instruction store never accepted word %0d", addr);
    end
  endtask

  task automatic remote_access(input logic w, input int word, input logic [31:0] data,
                               input logic [3:0] mask, output logic [31:0] rdata);
    int waited;
    drive_edge();
    remote_dmem_v_i = 1'b1;
    remote_dmem_req_i = '{w: w, addr: word * 4, data: data, mask: mask};
    waited = 0;
    @(negedge clk_i);
    while (!remote_dmem_yumi_o && waited < handshake_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!remote_dmem_yumi_o) begin
      hung = 1'b1;
      $display("remote port never accepted the request for word %0d", word);
    end
    drive_edge();
    remote_dmem_v_i = 1'b0;
    // read data sits in the memory's output register from here on
    @(negedge clk_i);
    rdata = remote_dmem_data_o;
  endtask

  task automatic remote_write(input int word, input logic [31:0] data, input logic [3:0] mask);
    logic [31:0] ignored;
    remote_access(1'b1, word, data, mask, ignored);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        exp_mem[word][8*b +: 8] = data[8*b +: 8];
      end
    end
    if (mask == 4'hf) begin
      exp_known[word] = 1'b1;
    end
  endtask

  task automatic begin_test();
    drive_edge();
    reset_i = 1'b1;
    reset_start = cycle_count;
    prog_len = 0;
    for (int k = 0; k < dmem_words; k++) begin
      exp_known[k] = 1'b0;
    end
  endtask

  task automatic launch();
    for (int k = 0; k < prog_len; k++) begin
      write_instr(k, prog[k]);
    end
    drive_edge();
    imem_v_i = 1'b0;
    while (cycle_count - reset_start < reset_cycles) begin
      drive_edge();
    end
    ref_run();
    reset_i = 1'b0;
    // at most three cycles per instruction with stalls and flushes, plus the pipe
    for (int c = 0; c < prog_len * 3 + 10; c++) begin
      drive_edge();
    end
  endtask

  task automatic finish_test(input string name);
    int checked;
    int bad;
    logic [31:0] got;
    checked = 0;
    bad = 0;
    for (int k = 0; k < dmem_words; k++) begin
      if (exp_known[k] && !hung) begin
        remote_access(1'b0, k, '0, '0, got);
        checked++;
        assert (got === exp_mem[k]) else begin
          $display("Mismatch remote_dmem_data_o word %0d: got %h expected %h",
                   k, got, exp_mem[k]);
          bad++;
        end
      end
    end
    tests_run++;
    total_mismatches += bad;
    if (bad != 0 || hung) begin
      tests_failed++;
    end
    $display("test %s: %0d words checked, %0d mismatches%s", name, checked, bad,
             hung ? ", stopped on a handshake timeout" : "");
  endtask

  task automatic test_alu();
    begin_test();
    emit(enc_i(op_imm, f3_add, 1, 0, 100));
    emit(enc_i(op_imm, f3_add, 2, 0, -7));
    emit(enc_lui(3, 20'h12345));
    emit(enc_i(op_imm, f3_or, 3, 3, 12'h678));
    emit(enc_i(op_imm, f3_and, 4, 3, 12'h0f0));
    emit(enc_i(op_imm, f3_xor, 5, 2, 12'h055));
    emit(enc_i(op_imm, f3_slt, 6, 2, -3));
    emit(enc_i(op_imm, f3_slt, 7, 1, 5));
    emit(enc_r(f3_add, 7'b0, 8, 1, 2));
    emit(enc_r(f3_add, f7_sub, 9, 2, 1));
    emit(enc_r(f3_and, 7'b0, 10, 3, 2));
    emit(enc_r(f3_or, 7'b0, 11, 1, 3));
    emit(enc_r(f3_xor, 7'b0, 12, 3, 1));
    emit(enc_r(f3_slt, 7'b0, 13, 2, 1));
    emit(enc_r(f3_slt, 7'b0, 14, 1, 2));
    for (int r = 1; r < 15; r++) begin
      emit(enc_s(r, 0, r * 4));
    end
    emit_halt();
    launch();
    finish_test("alu_ops");
  endtask

  task automatic test_forwarding();
    begin_test();
    emit(enc_i(op_imm, f3_add, 1, 0, 5));
    emit(enc_i(op_imm, f3_add, 2, 1, 3));
    emit(enc_i(op_imm, f3_add, 3, 1, 7));
    emit(enc_r(f3_add, 7'b0, 4, 2, 2));
    emit(enc_r(f3_add, 7'b0, 5, 4, 3));
    emit(enc_r(f3_add, f7_sub, 6, 5, 4));
    emit(enc_s(6, 0, 0));
    emit(enc_i(op_imm, f3_add, 7, 0, 16));
    emit(enc_s(5, 7, 0));
    emit(enc_s(4, 7, 4));
    emit(enc_r(f3_xor, 7'b0, 8, 6, 1));
    emit(enc_s(8, 0, 8));
    emit(enc_s(3, 0, 12));
    emit(enc_s(2, 7, 24));
    emit_halt();
    launch();
    finish_test("forwarding");
  endtask

  task automatic test_load_use();
    begin_test();
    remote_write(20, 32'h1000_0234, 4'hf);
    emit(enc_i(op_imm, f3_add, 1, 0, 80));
    emit(enc_i(op_load, f3_word, 2, 1, 0));
    emit(enc_r(f3_add, 7'b0, 3, 2, 1));
    emit(enc_s(3, 1, 4));
    emit(enc_i(op_load, f3_word, 4, 1, 0));
    emit(enc_s(4, 1, 8));
    emit(enc_i(op_load, f3_word, 5, 1, 4));
    emit(enc_r(f3_add, f7_sub, 6, 5, 2));
    emit(enc_s(6, 1, 12));
    emit_halt();
    launch();
    finish_test("load_use");
  endtask

  task automatic test_branches();
    begin_test();
    // markers in the words that skipped stores would overwrite
    remote_write(3, 32'hdead_beef, 4'hf);
    remote_write(5, 32'hcafe_f00d, 4'hf);
    emit(enc_i(op_imm, f3_add, 1, 0, 3));
    emit(enc_i(op_imm, f3_add, 2, 0, 3));
    emit(enc_i(op_imm, f3_add, 3, 0, 9));
    emit(enc_b(f3_beq, 1, 2, 8));
    emit(enc_i(op_imm, f3_add, 3, 0, 111));
    emit(enc_s(3, 0, 0));
    emit(enc_b(f3_bne, 1, 2, 8));
    emit(enc_i(op_imm, f3_add, 4, 0, 44));
    emit(enc_s(4, 0, 4));
    emit(enc_b(f3_beq, 1, 3, 8));
    emit(enc_s(1, 0, 8));
    emit(enc_b(f3_bne, 1, 3, 12));
    emit(enc_s(2, 0, 12));
    emit(enc_i(op_imm, f3_add, 3, 0, 222));
    emit(enc_jal(5, 12));
    emit(enc_s(1, 0, 20));
    emit(enc_i(op_imm, f3_add, 3, 0, 333));
    emit(enc_s(3, 0, 24));
    emit(enc_s(5, 0, 28));
    emit_halt();
    launch();
    finish_test("branches");
  endtask

  task automatic test_byte_mask();
    begin_test();
    emit(enc_lui(1, 20'h89abc));
    emit(enc_i(op_imm, f3_add, 1, 1, 12'h7ef));
    emit(enc_s(1, 0, 32));
    emit(enc_i(op_imm, f3_add, 2, 0, -1));
    emit(enc_s(2, 0, 36));
    emit(enc_s(1, 0, 40));
    emit_halt();
    launch();
    remote_write(8, 32'h1122_3344, 4'b0101);
    remote_write(9, 32'h0000_0000, 4'b1000);
    remote_write(8, 32'haabb_ccdd, 4'b0010);
    remote_write(10, 32'h5566_7788, 4'b1111);
    finish_test("byte_mask");
  endtask

  task automatic test_random(input int n);
    begin_test();
    build_random(24);
    launch();
    finish_test($sformatf("random_%0d", n));
  endtask

  initial begin
    void'($urandom(32'hd31));
    clk_i = 1'b0;
    reset_i = 1'b1;
    pc_init_val_i = '0;
    imem_v_i = 1'b0;
    imem_addr_i = '0;
    imem_instr_i = '0;
    remote_dmem_v_i = 1'b0;
    remote_dmem_req_i = '0;
    cycle_count = 0;
    hung = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    total_mismatches = 0;
    test_alu();
    test_forwarding();
    test_load_use();
    test_branches();
    test_byte_mask();
    for (int t = 0; t < 8; t++) begin
      test_random(t);
    end
    $display("tests run %0d, failed %0d, mismatches %0d",
             tests_run, tests_failed, total_mismatches);
    if (tests_failed == 0 && !hung) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
core_pkg.sv
fetch_stage.sv
decode_unit.sv
regfile.sv
alu.sv
hazard_unit.sv
data_mem.sv
vanilla_core.sv
tb_vanilla_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_vanilla_core -f all.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null &&
echo "run passed" || { echo "run failed"; exit 1; }
